// File: design/img_pkg.sv
`default_nettype none

package img_pkg;

    // ==============================
    // Image geometry
    // ==============================
    localparam int img_width   = 16;
    localparam int img_height  = 8;
    localparam int pixel_count = img_width * img_height;
    localparam int col_bits    = $clog2(img_width);
    localparam int line_bits   = $clog2(img_height);
    localparam int addr_bits   = $clog2(pixel_count);

    // Readout stream layout
    localparam int header_words   = 4;
    localparam int checksum_words = 2;
    localparam int padding_words  = 2;

    // Thumbnail keeps the upper-left thumb_keep x thumb_keep of each block
    localparam int thumb_block = 8;
    localparam int thumb_keep  = 2;

    // Statistics sample spacing and number of pixel MSBs that classify a sample
    localparam int stat_grid = 4;
    localparam int stat_msbs = 7;

    localparam int unsigned fletcher_mod = 65535;

    // ==============================
    // Types
    // ==============================
    typedef logic [11:0]                  pixel_t;
    typedef logic [15:0]                  word_t;
    typedef logic [addr_bits-1:0]         addr_t;
    typedef logic [addr_bits:0]           count_t;
    typedef logic [col_bits-1:0]          col_t;
    typedef logic [line_bits-1:0]         line_t;
    typedef logic [15:0]                  stat_t;
    typedef logic [31:0]                  sum_t;
    typedef logic [header_words*16-1:0]   header_t;

    typedef enum logic [1:0] {
        cap_idle,
        cap_wait_frame,
        cap_store
    } capture_state_t;

    typedef enum logic [2:0] {
        rd_idle,
        rd_header,
        rd_pixels,
        rd_checksum,
        rd_padding,
        rd_drain
    } readout_state_t;

endpackage

`default_nettype wire

// File: design/pixel_capture.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_capture (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  start,
    input  wire                  skip,
    input  wire                  pix_fv,
    input  wire                  pix_lv,
    input  wire img_pkg::pixel_t pix_data,
    output logic                 busy,
    output logic                 done,
    output logic                 wr_en,
    output img_pkg::addr_t       wr_addr,
    output img_pkg::word_t       wr_data,
    output img_pkg::count_t      pixels,
    output img_pkg::stat_t       highlights,
    output img_pkg::stat_t       shadows
);
    img_pkg::capture_state_t state;
    logic fv_prev;
    logic lv_prev;
    logic skip_left;
    img_pkg::col_t col;
    img_pkg::line_t line;
    logic frame_start;
    logic frame_end;
    logic line_end;
    logic take_frame;
    logic storing;
    logic sample;
    logic [img_pkg::stat_msbs-1:0] pix_top;

    // ==============================
    // Sensor strobe tracking
    // ==============================
    assign frame_start = pix_fv && !fv_prev;
    assign frame_end   = fv_prev && !pix_fv;
    assign line_end    = lv_prev && !pix_lv;

    always_ff @(posedge clk) begin
        if (reset) begin
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            col     <= '0;
            line    <= '0;
        end else begin
            fv_prev <= pix_fv;
            lv_prev <= pix_lv;
            col     <= pix_lv ? col + 1'b1 : '0;
            if (!pix_fv) begin
                line <= '0;
            end else if (line_end) begin
                line <= line + 1'b1;
            end
        end
    end

    // Pixels on the frame-start cycle already belong to the stored frame
    assign take_frame = (state == img_pkg::cap_wait_frame) && frame_start && !skip_left;
    assign storing    = ((state == img_pkg::cap_store) || take_frame) && pix_lv;
    assign sample     = storing && ((col % img_pkg::stat_grid) == 0)
                        && ((line % img_pkg::stat_grid) == 0);
    assign pix_top    = pix_data[$bits(img_pkg::pixel_t)-1 -: img_pkg::stat_msbs];
    assign busy       = (state != img_pkg::cap_idle);

    // ==============================
    // Capture FSM and statistics
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= img_pkg::cap_idle;
            skip_left  <= 1'b0;
            done       <= 1'b0;
            wr_en      <= 1'b0;
            pixels     <= '0;
            highlights <= '0;
            shadows    <= '0;
        end else begin
            done  <= 1'b0;
            wr_en <= storing;
            case (state)
                img_pkg::cap_idle: begin
                    if (start) begin
                        pixels     <= '0;
                        highlights <= '0;
                        shadows    <= '0;
                        skip_left  <= skip;
                        state      <= img_pkg::cap_wait_frame;
                    end
                end
                img_pkg::cap_wait_frame: begin
                    // A skipped frame just uses up one frame start
                    if (frame_start) begin
                        if (skip_left) begin
                            skip_left <= 1'b0;
                        end else begin
                            state <= img_pkg::cap_store;
                        end
                    end
                end
                img_pkg::cap_store: begin
                    if (frame_end) begin
                        done  <= 1'b1;
                        state <= img_pkg::cap_idle;
                    end
                end
                default: state <= img_pkg::cap_idle;
            endcase

            if (storing) begin
                pixels <= pixels + 1'b1;
                if (sample && (&pix_top)) begin
                    highlights <= highlights + 1'b1;
                end
                if (sample && !(|pix_top)) begin
                    shadows <= shadows + 1'b1;
                end
            end
        end
    end

    // Write port follows the sample by one cycle
    always_ff @(posedge clk) begin
        wr_addr <= img_pkg::addr_t'(pixels);
        wr_data <= img_pkg::word_t'(pix_data);
    end

    a_wr_in_range: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> ($past(pixels) < img_pkg::count_t'(img_pkg::pixel_count)));

endmodule

`default_nettype wire

// File: design/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
    input  wire                 clk,
    input  wire                 wr_en,
    input  wire img_pkg::addr_t wr_addr,
    input  wire img_pkg::word_t wr_data,
    input  wire                 rd_en,
    input  wire img_pkg::addr_t rd_addr,
    output img_pkg::word_t      rd_data
);
    // One word per pixel, in raster order
    img_pkg::word_t mem [img_pkg::pixel_count];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: design/fletcher_checksum.sv
`timescale 1ns/10ps
`default_nettype none

module fletcher_checksum (
    input  wire                 clk,
    input  wire                 clear,
    input  wire                 add_en,
    input  wire img_pkg::word_t add_word,
    output img_pkg::sum_t       sum
);
    img_pkg::word_t sum1;
    img_pkg::word_t sum2;
    img_pkg::word_t sum1_next;
    img_pkg::word_t sum2_next;

    // Addition modulo 65535 of a reduced sum and a raw or reduced word
    function automatic img_pkg::word_t add_mod(input img_pkg::word_t a,
                                               input img_pkg::word_t b);
        logic [16:0] total;
        total = {1'b0, a} + {1'b0, b};
        if (total >= 17'(img_pkg::fletcher_mod)) begin
            total = total - 17'(img_pkg::fletcher_mod);
        end
        return total[15:0];
    endfunction

    assign sum1_next = add_mod(sum1, add_word);
    assign sum2_next = add_mod(sum2, sum1_next);
    assign sum       = {sum2, sum1};

    always_ff @(posedge clk) begin
        if (clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (add_en) begin
            sum1 <= sum1_next;
            sum2 <= sum2_next;
        end
    end

endmodule

`default_nettype wire

// File: design/readout_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module readout_sequencer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  wire                   thumb,
    input  wire img_pkg::header_t header,
    input  wire img_pkg::word_t   rd_data,
    input  wire img_pkg::sum_t    sum,
    input  wire                   out_ready,
    output logic                  busy,
    output logic                  rd_en,
    output img_pkg::addr_t        rd_addr,
    output logic                  ck_clear,
    output logic                  ck_add,
    output img_pkg::word_t        ck_word,
    output logic                  out_valid,
    output img_pkg::word_t        out_data,
    output logic                  out_last
);
    img_pkg::readout_state_t state;
    img_pkg::header_t hdr_shift;
    logic thumb_mode;
    img_pkg::count_t word_cnt;
    img_pkg::count_t fetch_cnt;
    img_pkg::col_t col;
    img_pkg::line_t line;
    logic rd_valid;
    logic rd_keep;
    logic out_ck;
    logic load;
    logic fetch_more;
    logic keep;

    // Output register is free when empty or being taken
    assign load       = !out_valid || out_ready;
    assign fetch_more = fetch_cnt < img_pkg::count_t'(img_pkg::pixel_count);
    assign keep       = !thumb_mode
                        || (((col % img_pkg::thumb_block) < img_pkg::thumb_keep)
                        && ((line % img_pkg::thumb_block) < img_pkg::thumb_keep));

    assign rd_en    = (state == img_pkg::rd_pixels) && load && fetch_more;
    assign rd_addr  = img_pkg::addr_t'(fetch_cnt);
    assign busy     = (state != img_pkg::rd_idle);
    assign ck_clear = (state == img_pkg::rd_idle) && start;
    assign ck_add   = out_valid && out_ready && out_ck;
    assign ck_word  = out_data;

    // ==============================
    // Stream FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= img_pkg::rd_idle;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_ck    <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b0;
                out_last  <= 1'b0;
            end
            case (state)
                img_pkg::rd_idle: begin
                    if (start) begin
                        hdr_shift  <= header;
                        thumb_mode <= thumb;
                        word_cnt   <= img_pkg::count_t'(img_pkg::header_words);
                        state      <= img_pkg::rd_header;
                    end
                end
                img_pkg::rd_header: begin
                    if (load) begin
                        out_valid <= 1'b1;
                        out_ck    <= 1'b1;
                        out_data  <= hdr_shift[$bits(img_pkg::header_t)-1 -: 16];
                        hdr_shift <= hdr_shift << 16;
                        word_cnt  <= word_cnt - 1'b1;
                        if (word_cnt == 1) begin
                            fetch_cnt <= '0;
                            col       <= '0;
                            line      <= '0;
                            rd_valid  <= 1'b0;
                            state     <= img_pkg::rd_pixels;
                        end
                    end
                end
                img_pkg::rd_pixels: begin
                    // rd_data holds a fetched pixel until the output register takes it
                    if (load) begin
                        if (rd_valid && rd_keep) begin
                            out_valid <= 1'b1;
                            out_ck    <= 1'b1;
                            out_data  <= rd_data;
                        end
                        rd_valid <= rd_en;
                        if (!fetch_more) begin
                            state <= img_pkg::rd_drain;
                        end
                    end
                    if (rd_en) begin
                        rd_keep   <= keep;
                        fetch_cnt <= fetch_cnt + 1'b1;
                        if (col == img_pkg::col_t'(img_pkg::img_width - 1)) begin
                            col  <= '0;
                            line <= line + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                img_pkg::rd_drain: begin
                    // Once the last pixel is taken the sum has it a cycle later
                    if (!out_valid) begin
                        word_cnt <= img_pkg::count_t'(img_pkg::checksum_words);
                        state    <= img_pkg::rd_checksum;
                    end
                end
                img_pkg::rd_checksum: begin
                    if (load) begin
                        out_valid <= 1'b1;
                        out_ck    <= 1'b0;
                        out_data  <= (word_cnt == img_pkg::checksum_words) ? sum[31:16]
                                                                           : sum[15:0];
                        word_cnt  <= word_cnt - 1'b1;
                        if (word_cnt == 1) begin
                            word_cnt <= img_pkg::count_t'(img_pkg::padding_words);
                            state    <= img_pkg::rd_padding;
                        end
                    end
                end
                img_pkg::rd_padding: begin
                    if (load && (word_cnt != 0)) begin
                        out_valid <= 1'b1;
                        out_data  <= '0;
                        out_last  <= (word_cnt == 1);
                        word_cnt  <= word_cnt - 1'b1;
                    end
                    if (out_valid && out_ready && out_last) begin
                        state <= img_pkg::rd_idle;
                    end
                end
                default: state <= img_pkg::rd_idle;
            endcase
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)));

endmodule

`default_nettype wire

// File: design/img_controller.sv
`timescale 1ns/10ps
`default_nettype none

module img_controller (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   pix_fv,
    input  wire                   pix_lv,
    input  wire img_pkg::pixel_t  pix_data,
    input  wire                   cmd_capture,
    input  wire                   cmd_skip,
    input  wire                   cmd_readout,
    input  wire                   cmd_thumb,
    input  wire img_pkg::header_t cmd_header,
    input  wire                   out_ready,
    output wire                   out_valid,
    output wire img_pkg::word_t   out_data,
    output wire                   out_last,
    output wire                   capture_done,
    output wire                   capture_busy,
    output wire                   readout_busy,
    output wire img_pkg::count_t  capture_pixels,
    output wire img_pkg::stat_t   highlight_count,
    output wire img_pkg::stat_t   shadow_count
);
    // Capture to buffer
    wire                 wr_en;
    wire img_pkg::addr_t wr_addr;
    wire img_pkg::word_t wr_data;

    // Buffer to sequencer
    wire                 rd_en;
    wire img_pkg::addr_t rd_addr;
    wire img_pkg::word_t rd_data;

    // Sequencer and checksum
    wire                 ck_clear;
    wire                 ck_add;
    wire img_pkg::word_t ck_word;
    wire img_pkg::sum_t  ck_sum;

    pixel_capture capture0 (
        .clk        (clk),
        .reset      (reset),
        .start      (cmd_capture),
        .skip       (cmd_skip),
        .pix_fv     (pix_fv),
        .pix_lv     (pix_lv),
        .pix_data   (pix_data),
        .busy       (capture_busy),
        .done       (capture_done),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .pixels     (capture_pixels),
        .highlights (highlight_count),
        .shadows    (shadow_count)
    );

    frame_buffer buffer0 (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fletcher_checksum checksum0 (
        .clk      (clk),
        .clear    (ck_clear),
        .add_en   (ck_add),
        .add_word (ck_word),
        .sum      (ck_sum)
    );

    readout_sequencer sequencer0 (
        .clk       (clk),
        .reset     (reset),
        .start     (cmd_readout),
        .thumb     (cmd_thumb),
        .header    (cmd_header),
        .rd_data   (rd_data),
        .sum       (ck_sum),
        .out_ready (out_ready),
        .busy      (readout_busy),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .ck_clear  (ck_clear),
        .ck_add    (ck_add),
        .ck_word   (ck_word),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

// File: bench/img_controller_tb.sv
`timescale 1ns/10ps
`default_nettype none

module img_controller_tb;

    localparam int clk_period   = 8;
    localparam int wait_limit   = 2000;
    localparam int num_rows     = 4;
    localparam int fletcher_mod = 65535;
    localparam int grid_samples = (img_pkg::img_width / img_pkg::stat_grid)
                                  * (img_pkg::img_height / img_pkg::stat_grid);

    typedef struct packed {
        logic             skip;
        logic             thumb;
        logic             backpressure;
        img_pkg::header_t header;
        int               force_high;
        int               force_low;
        int               exp_pixels;
        int               exp_high;
        int               exp_low;
    } row_t;

    logic clk;
    logic reset;
    logic pix_fv;
    logic pix_lv;
    img_pkg::pixel_t pix_data;
    logic cmd_capture;
    logic cmd_skip;
    logic cmd_readout;
    logic cmd_thumb;
    img_pkg::header_t cmd_header;
    logic out_ready;
    logic out_valid;
    img_pkg::word_t out_data;
    logic out_last;
    logic capture_done;
    logic capture_busy;
    logic readout_busy;
    img_pkg::count_t capture_pixels;
    img_pkg::stat_t highlight_count;
    img_pkg::stat_t shadow_count;

    logic [31:0] rng;
    img_pkg::pixel_t frame_model [img_pkg::pixel_count];
    img_pkg::word_t expect_q [$];

    // ==============================
    // Scenario table
    // ==============================
    // skip, thumb, backpressure, header, forced highlights, forced shadows,
    // expected pixels, highlights, shadows
    row_t scenarios [num_rows] = '{
        '{1'b0, 1'b0, 1'b0, 64'h1234_5678_9abc_def0, 2, 1, 128, 2, 1},
        '{1'b1, 1'b0, 1'b1, 64'hffff_0000_a5a5_5a5a, 0, 3, 128, 0, 3},
        '{1'b0, 1'b1, 1'b0, 64'h0f0f_f0f0_1111_eeee, 4, 4, 128, 4, 4},
        '{1'b1, 1'b1, 1'b1, 64'h8001_7ffe_0000_ffff, 1, 0, 128, 1, 0}
    };

    img_controller dut0 (
        .clk             (clk),
        .reset           (reset),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .pix_data        (pix_data),
        .cmd_capture     (cmd_capture),
        .cmd_skip        (cmd_skip),
        .cmd_readout     (cmd_readout),
        .cmd_thumb       (cmd_thumb),
        .cmd_header      (cmd_header),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_last        (out_last),
        .capture_done    (capture_done),
        .capture_busy    (capture_busy),
        .readout_busy    (readout_busy),
        .capture_pixels  (capture_pixels),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %0h expected %0h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Grid samples are forced in raster order, the rest stay clear of both classes
    task automatic make_pixel(input int col, input int line, input int n_high,
                              input int n_low, output img_pkg::pixel_t pix);
        int k;
        rng = xorshift(rng);
        pix = rng[11:0];
        if (((col % img_pkg::stat_grid) == 0) && ((line % img_pkg::stat_grid) == 0)) begin
            k = (line / img_pkg::stat_grid) * (img_pkg::img_width / img_pkg::stat_grid)
                + col / img_pkg::stat_grid;
            if (k < n_high) begin
                pix = {7'h7f, rng[4:0]};
            end else if (k < n_high + n_low) begin
                pix = {7'h00, rng[4:0]};
            end else begin
                pix = {2'b01, rng[9:0]};
            end
        end
    endtask

    // ==============================
    // Sensor model
    // ==============================
    task automatic send_frame(input logic keep, input int n_high, input int n_low);
        img_pkg::pixel_t pix;
        @(negedge clk);
        pix_fv = 1'b1;
        for (int line = 0; line < img_pkg::img_height; line++) begin
            // Line blanking doubles as the gap after frame start
            idle_cycles(2);
            for (int col = 0; col < img_pkg::img_width; col++) begin
                make_pixel(col, line, n_high, n_low, pix);
                if (keep) begin
                    frame_model[line * img_pkg::img_width + col] = pix;
                end
                pix_lv   = 1'b1;
                pix_data = pix;
                @(negedge clk);
            end
            pix_lv = 1'b0;
        end
        idle_cycles(2);
        pix_fv = 1'b0;
    endtask

    task automatic wait_capture_done();
        int n;
        for (n = 0; (n < wait_limit) && (capture_done !== 1'b1); n++) begin
            @(negedge clk);
        end
        if (capture_done !== 1'b1) begin
            report_timeout("capture_done");
        end
    endtask

    task automatic run_capture(input row_t row);
        @(negedge clk);
        cmd_capture = 1'b1;
        cmd_skip    = row.skip;
        @(negedge clk);
        cmd_capture = 1'b0;
        cmd_skip    = 1'b0;
        compare_value("capture_busy", capture_busy, 1);
        idle_cycles(2);
        if (row.skip) begin
            // Skipped frame is all highlights, so storing it would show
            send_frame(1'b0, grid_samples, 0);
            idle_cycles(4);
        end
        send_frame(1'b1, row.force_high, row.force_low);
        wait_capture_done();
        compare_value("capture_busy", capture_busy, 0);
        compare_value("capture_pixels", capture_pixels, row.exp_pixels);
        compare_value("highlight_count", highlight_count, row.exp_high);
        compare_value("shadow_count", shadow_count, row.exp_low);
        @(negedge clk);
        compare_value("capture_done", capture_done, 0);
    endtask

    // ==============================
    // Reference stream
    // ==============================
    task automatic build_stream(input row_t row);
        int i;
        int s1;
        int s2;
        logic keep;
        expect_q.delete();
        for (i = 0; i < img_pkg::header_words; i++) begin
            expect_q.push_back(row.header[(img_pkg::header_words - 1 - i) * 16 +: 16]);
        end
        for (int line = 0; line < img_pkg::img_height; line++) begin
            for (int col = 0; col < img_pkg::img_width; col++) begin
                keep = !row.thumb || (((col % img_pkg::thumb_block) < 2)
                                      && ((line % img_pkg::thumb_block) < 2));
                if (keep) begin
                    expect_q.push_back({4'h0, frame_model[line * img_pkg::img_width + col]});
                end
            end
        end
        // Fletcher-32 over header and pixels
        s1 = 0;
        s2 = 0;
        for (i = 0; i < expect_q.size(); i++) begin
            s1 = (s1 + expect_q[i]) % fletcher_mod;
            s2 = (s2 + s1) % fletcher_mod;
        end
        expect_q.push_back(s2[15:0]);
        expect_q.push_back(s1[15:0]);
        for (i = 0; i < img_pkg::padding_words; i++) begin
            expect_q.push_back(16'h0000);
        end
    endtask

    task automatic run_readout(input row_t row);
        int idx;
        int n;
        logic stalled;
        logic finished;
        img_pkg::word_t held_data;
        logic held_last;
        build_stream(row);
        @(negedge clk);
        cmd_readout = 1'b1;
        cmd_thumb   = row.thumb;
        cmd_header  = row.header;
        @(negedge clk);
        cmd_readout = 1'b0;
        cmd_thumb   = 1'b0;
        cmd_header  = '0;
        compare_value("readout_busy", readout_busy, 1);
        idx       = 0;
        stalled   = 1'b0;
        finished  = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        for (n = 0; (n < 4 * wait_limit) && !finished; n++) begin
            if (stalled) begin
                compare_value("out_valid", out_valid, 1);
                compare_value("out_data", out_data, held_data);
                compare_value("out_last", out_last, held_last);
            end
            if (row.backpressure) begin
                rng       = xorshift(rng);
                out_ready = (rng[1:0] != 2'b00);
            end else begin
                out_ready = 1'b1;
            end
            stalled   = out_valid && !out_ready;
            held_data = out_data;
            held_last = out_last;
            if (out_valid && out_ready) begin
                compare_value("out_data", out_data, expect_q[idx]);
                compare_value("out_last", out_last, idx == expect_q.size() - 1);
                finished = out_last;
                idx++;
            end
            @(negedge clk);
        end
        if (!finished) begin
            report_timeout("the last readout word");
        end else begin
            out_ready = 1'b0;
            compare_value("readout_busy", readout_busy, 0);
            compare_value("out_valid", out_valid, 0);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        row_t row;
        rng         = 32'd64859;
        reset       = 1'b1;
        pix_fv      = 1'b0;
        pix_lv      = 1'b0;
        pix_data    = '0;
        cmd_capture = 1'b0;
        cmd_skip    = 1'b0;
        cmd_readout = 1'b0;
        cmd_thumb   = 1'b0;
        cmd_header  = '0;
        out_ready   = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        compare_value("out_valid", out_valid, 0);
        compare_value("out_last", out_last, 0);
        compare_value("capture_done", capture_done, 0);
        compare_value("capture_busy", capture_busy, 0);
        compare_value("readout_busy", readout_busy, 0);
        compare_value("capture_pixels", capture_pixels, 0);
        compare_value("highlight_count", highlight_count, 0);
        compare_value("shadow_count", shadow_count, 0);

        for (int r = 0; r < num_rows; r++) begin
            row = scenarios[r];
            run_capture(row);
            idle_cycles(3);
            run_readout(row);
            idle_cycles(3);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/img_pkg.sv
design/pixel_capture.sv
design/frame_buffer.sv
design/fletcher_checksum.sv
design/readout_sequencer.sv
design/img_controller.sv
bench/img_controller_tb.sv

// File: Bender.yml
package:
  name: img_controller

sources:
  - design/img_pkg.sv
  - design/pixel_capture.sv
  - design/frame_buffer.sv
  - design/fletcher_checksum.sv
  - design/readout_sequencer.sv
  - design/img_controller.sv
  - target: test
    files:
      - bench/img_controller_tb.sv
